//--- Makefile
# Verilator build and run of the memory-stage subsystem testbench

VERILATOR ?= verilator
TOP       ?= memSubsystemTb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/100ps -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "^SIMULATION PASSED$$" $(LOG); then \
	  echo "test passed"; \
	else \
	  echo "test failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- design/busArbiter.sv
/*
  Round-robin arbiter for the shared memory bus.
  Grants one requester at a time, muxes its fields onto the
  memory port and returns the acknowledge to the owner.
*/
module busArbiter import memPkg::*, busPkg::*; (
  input  logic    clk,
  input  logic    arstN,
  // data requester
  input  logic    reqData,
  input  logic    wrData,
  input  wordAdrT adrData,
  input  dataT    wdataData,
  input  byteEnT  byteEnData,
  output logic    ackData,
  // fetch requester, reads only
  input  logic    reqFetch,
  input  wordAdrT adrFetch,
  output logic    ackFetch,
  // memory port
  output logic    memReq,
  output logic    memWrite,
  output wordAdrT memAdr,
  output dataT    memWdata,
  output byteEnT  memByteEn,
  input  logic    memAck
);

  logic [NUM_REQ-1:0] reqVec;
  grantT              owner, pick, grant;
  logic               fetchFirst;

  assign reqVec = {reqFetch, reqData};

  // choice for an idle bus, priority flips after each access
  always_comb begin
    pick = grantNone;
    if (&reqVec)
      pick = fetchFirst ? grantFetch : grantData;
    else if (reqVec[REQ_DATA])
      pick = grantData;
    else if (reqVec[REQ_FETCH])
      pick = grantFetch;
  end

  // owner keeps the bus until memAck
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      owner      <= grantNone;
      fetchFirst <= 1'b0;
    end else if (owner == grantNone) begin
      owner <= pick;
    end else if (memAck) begin
      owner      <= grantNone;
      fetchFirst <= (owner == grantData);
    end
  end

  // idle bus grants in the same cycle as the request
  assign grant = (owner == grantNone) ? pick : owner;

  assign memReq    = (grant != grantNone);
  assign memWrite  = (grant == grantData) & wrData;
  assign memAdr    = (grant == grantFetch) ? adrFetch : adrData;
  assign memWdata  = wdataData;
  assign memByteEn = (grant == grantFetch) ? byteEnT'('1) : byteEnData;

  assign ackData  = memAck & (owner == grantData);
  assign ackFetch = memAck & (owner == grantFetch);

endmodule

//--- design/busPkg.sv
/*
  Bus-side definitions for the shared word memory bus.
  Byte enable and word index types, requester slots and
  the arbiter's grant encoding.
*/
package busPkg;

  // one enable per byte lane of a data word
  typedef logic [3:0] byteEnT;

  // word index into the SRAM
  typedef logic [9:0] wordAdrT;

  // requesters on the bus
  localparam int NUM_REQ   = 2;
  localparam int REQ_DATA  = 0;
  localparam int REQ_FETCH = 1;

  // current bus owner
  typedef enum logic [1:0] {
    grantNone,
    grantData,
    grantFetch
  } grantT;

endpackage

//--- design/dataMemUnit.sv
/*
  Data memory unit of the memory stage.
  Checks alignment and range, builds the subword datapath, keeps the
  LR/SC reservation and runs the request FSM toward the memory bus.
*/
module dataMemUnit import memPkg::*, busPkg::*; (
  input  logic        clk,
  input  logic        arstN,
  input  logic        stall,
  // core side, held until dataDone
  input  memRwT       memRw,
  input  addrT        memAdr,
  input  funct3T      funct3,
  input  dataT        writeData,
  input  atomicT      atomic,
  output dataT        readData,
  output logic        dataDone,
  output logic        scFail,
  output logic        loadMisalignedFault,
  output logic        storeMisalignedFault,
  output logic        loadAccessFault,
  output logic        storeAccessFault,
  // bus side
  output logic        reqData,
  output logic        wrData,
  output wordAdrT     adrData,
  output dataT        wdataData,
  output byteEnT      byteEnData,
  input  logic        ackData,
  input  dataT        busRdata
);

  accessStateT state, nextState;
  logic        misaligned, accessFault, anyFault;
  logic        isLr, isSc, resMatch, scSquash;
  logic        accept, wrPhase, signExt;
  logic        resValid;
  logic [$bits(addrT)-3:0] resWord;
  logic [1:0]  byteOff;
  dataT        loadShifted, loadExt;

  ////////////////////////////////////////////////////////////////////
  // fault decode
  ////////////////////////////////////////////////////////////////////

  assign byteOff = memAdr[1:0];

  // natural alignment by access size
  always_comb begin
    case (funct3[1:0])
      SIZE_HALF: misaligned = memAdr[0];
      SIZE_WORD: misaligned = |memAdr[1:0];
      default:   misaligned = 1'b0;
    endcase
  end

  // out of range or doubleword, misalignment takes priority
  assign accessFault = ~misaligned &
                       ((memAdr >= MEM_TOP) | (funct3[1:0] == SIZE_DOUBLE));
  assign anyFault    = misaligned | accessFault;

  ////////////////////////////////////////////////////////////////////
  // LR/SC reservation
  ////////////////////////////////////////////////////////////////////

  assign isLr     = (memRw == RW_READ) & atomic[ATOMIC_LRSC];
  assign isSc     = (memRw == RW_WRITE) & atomic[ATOMIC_LRSC];
  assign resMatch = resValid & (resWord == memAdr[$bits(addrT)-1:2]);
  // sc with no live reservation on this word never reaches the bus
  assign scSquash = isSc & ~resMatch;

  // new request is taken only from the ready state
  assign accept = (state == accessReady) & (|memRw);

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      resValid <= 1'b0;
    end else if (accept) begin
      if (isLr & ~anyFault)
        resValid <= 1'b1;
      // any sc, or a store hitting the reserved word, drops it
      else if (isSc | (memRw[0] & resMatch & ~anyFault))
        resValid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept & isLr & ~anyFault)
      resWord <= memAdr[$bits(addrT)-1:2];
  end

  ////////////////////////////////////////////////////////////////////
  // request FSM
  ////////////////////////////////////////////////////////////////////

  always_comb begin
    nextState = state;
    case (state)
      accessReady: begin
        // faulted or squashed accesses finish without the bus
        if (accept & (anyFault | scSquash))
          nextState = accessStalled;
        else if (accept & (memRw == RW_AMO))
          nextState = accessFetchAmo;
        else if (accept)
          nextState = accessFetch;
      end
      // amo read phase, write phase follows
      accessFetchAmo: if (ackData) nextState = accessFetch;
      accessFetch: begin
        if (ackData)
          nextState = stall ? accessStalled : accessReady;
      end
      // hold the result until writeback moves
      accessStalled: if (~stall) nextState = accessReady;
      default: nextState = accessReady;
    endcase
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN)
      state <= accessReady;
    else
      state <= nextState;
  end

  // flags are latched at acceptance and held through completion
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      loadMisalignedFault  <= 1'b0;
      storeMisalignedFault <= 1'b0;
      loadAccessFault      <= 1'b0;
      storeAccessFault     <= 1'b0;
      scFail               <= 1'b0;
    end else if (accept) begin
      loadMisalignedFault  <= misaligned & memRw[1];
      storeMisalignedFault <= misaligned & memRw[0];
      loadAccessFault      <= accessFault & memRw[1];
      storeAccessFault     <= accessFault & memRw[0];
      scFail               <= scSquash & ~anyFault;
    end
  end

  assign dataDone = ((state == accessFetch) & ackData) | (state == accessStalled);

  ////////////////////////////////////////////////////////////////////
  // subword datapath
  ////////////////////////////////////////////////////////////////////

  // write phase of a plain store or of an amo
  assign wrPhase = (state == accessFetch) & memRw[0];

  assign reqData   = (state == accessFetchAmo) | (state == accessFetch);
  assign wrData    = wrPhase;
  assign adrData   = memAdr[$bits(wordAdrT)+1:2];
  // store data moved onto its byte lanes
  assign wdataData = writeData << {byteOff, 3'b000};

  always_comb begin
    case (funct3[1:0])
      SIZE_BYTE: byteEnData = byteEnT'(4'b0001) << byteOff;
      SIZE_HALF: byteEnData = byteEnT'(4'b0011) << byteOff;
      default:   byteEnData = '1;
    endcase
  end

  // load lane to bit 0, then extend
  assign loadShifted = busRdata >> {byteOff, 3'b000};
  assign signExt     = ~funct3[F3_UNSIGNED];

  always_comb begin
    case (funct3[1:0])
      SIZE_BYTE: loadExt = {{24{signExt & loadShifted[7]}}, loadShifted[7:0]};
      SIZE_HALF: loadExt = {{16{signExt & loadShifted[15]}}, loadShifted[15:0]};
      default:   loadExt = loadShifted;
    endcase
  end

  // amo keeps the old word from its read phase
  always_ff @(posedge clk) begin
    if (ackData & ~wrPhase)
      readData <= loadExt;
  end

endmodule

//--- design/fetchUnit.sv
/*
  Instruction fetch requester.
  Reads aligned instruction words over the shared bus, flags
  misaligned fetch addresses and holds the word through stall.
*/
module fetchUnit import memPkg::*, busPkg::*; (
  input  logic    clk,
  input  logic    arstN,
  input  logic    stall,
  // core side, held until fetchDone
  input  logic    fetchReq,
  input  addrT    fetchAdr,
  output dataT    instr,
  output logic    fetchDone,
  output logic    fetchMisalignedFault,
  // bus side, read only
  output logic    reqFetch,
  output wordAdrT adrFetch,
  input  logic    ackFetch,
  input  dataT    busRdata
);

  accessStateT state, nextState;
  logic        misaligned;

  // instructions are whole aligned words here
  assign misaligned = |fetchAdr[1:0];

  always_comb begin
    nextState = state;
    case (state)
      accessReady: begin
        // misaligned fetch completes without a bus access
        if (fetchReq)
          nextState = misaligned ? accessStalled : accessFetch;
      end
      accessFetch: begin
        if (ackFetch)
          nextState = stall ? accessStalled : accessReady;
      end
      accessStalled: if (~stall) nextState = accessReady;
      // no amo phase on the fetch side
      default: nextState = accessReady;
    endcase
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state                <= accessReady;
      fetchMisalignedFault <= 1'b0;
    end else begin
      state <= nextState;
      if ((state == accessReady) & fetchReq)
        fetchMisalignedFault <= misaligned;
    end
  end

  // word captured with the acknowledge
  always_ff @(posedge clk) begin
    if (ackFetch)
      instr <= busRdata;
  end

  assign reqFetch  = (state == accessFetch);
  assign adrFetch  = fetchAdr[$bits(wordAdrT)+1:2];
  assign fetchDone = ((state == accessFetch) & ackFetch) | (state == accessStalled);

endmodule

//--- design/memPkg.sv
/*
  Core-side definitions for the memory stage.
  Address and data types, funct3 size codes, the access FSM states
  and the size of the on-chip data memory.
*/
package memPkg;

  // byte address and data word
  typedef logic [31:0] addrT;
  typedef logic [31:0] dataT;

  // load/store funct3 straight from the instruction
  typedef logic [2:0] funct3T;

  // bit 1 is read and bit 0 is write, both set for an AMO
  typedef logic [1:0] memRwT;

  // bit 0 marks LR/SC, bit 1 marks AMO swap
  typedef logic [1:0] atomicT;

  localparam memRwT RW_READ  = 2'b10;
  localparam memRwT RW_WRITE = 2'b01;
  localparam memRwT RW_AMO   = 2'b11;
  localparam int ATOMIC_LRSC = 0;

  // access size in funct3[1:0]
  localparam logic [1:0] SIZE_BYTE   = 2'b00;
  localparam logic [1:0] SIZE_HALF   = 2'b01;
  localparam logic [1:0] SIZE_WORD   = 2'b10;
  localparam logic [1:0] SIZE_DOUBLE = 2'b11;
  // funct3[2] set means zero-extend on load
  localparam int F3_UNSIGNED = 2;

  // request FSM shared by the data and fetch requesters
  typedef enum logic [1:0] {
    accessReady,
    accessFetch,
    accessFetchAmo,
    accessStalled
  } accessStateT;

  // on-chip memory, accesses at or above MEM_TOP fault
  localparam int MEM_WORDS = 1024;
  localparam addrT MEM_TOP = addrT'(MEM_WORDS * 4);

endpackage

//--- design/memSubsystem.sv
/*
  Memory-stage subsystem top.
  Data unit and fetch unit share the SRAM through the arbiter.
*/
module memSubsystem (
  input  logic        clk,
  input  logic        arstN,
  input  logic        stall,
  // core data port
  input  logic [1:0]  memRw,
  input  logic [31:0] memAdr,
  input  logic [2:0]  funct3,
  input  logic [31:0] writeData,
  input  logic [1:0]  atomic,
  output logic [31:0] readData,
  output logic        dataDone,
  output logic        scFail,
  output logic        loadMisalignedFault,
  output logic        storeMisalignedFault,
  output logic        loadAccessFault,
  output logic        storeAccessFault,
  // core fetch port
  input  logic        fetchReq,
  input  logic [31:0] fetchAdr,
  output logic [31:0] instr,
  output logic        fetchDone,
  output logic        fetchMisalignedFault
);

  // requester ports
  logic        reqData, wrData, ackData;
  logic [9:0]  adrData;
  logic [31:0] wdataData;
  logic [3:0]  byteEnData;
  logic        reqFetch, ackFetch;
  logic [9:0]  adrFetch;
  // memory port
  logic        sramReq, sramWrite, sramAck;
  logic [9:0]  sramAdr;
  logic [31:0] sramWdata, busRdata;
  logic [3:0]  sramByteEn;

  dataMemUnit dataMemUnit_i (
    .clk, .arstN, .stall,
    .memRw, .memAdr, .funct3, .writeData, .atomic,
    .readData, .dataDone, .scFail,
    .loadMisalignedFault, .storeMisalignedFault,
    .loadAccessFault, .storeAccessFault,
    .reqData, .wrData, .adrData, .wdataData, .byteEnData,
    .ackData, .busRdata
  );

  fetchUnit fetchUnit_i (
    .clk, .arstN, .stall,
    .fetchReq, .fetchAdr, .instr, .fetchDone, .fetchMisalignedFault,
    .reqFetch, .adrFetch, .ackFetch, .busRdata
  );

  busArbiter busArbiter_i (
    .clk, .arstN,
    .reqData, .wrData, .adrData, .wdataData, .byteEnData, .ackData,
    .reqFetch, .adrFetch, .ackFetch,
    .memReq(sramReq), .memWrite(sramWrite), .memAdr(sramAdr),
    .memWdata(sramWdata), .memByteEn(sramByteEn), .memAck(sramAck)
  );

  sramBus sramBus_i (
    .clk, .arstN,
    .memReq(sramReq), .memWrite(sramWrite), .memAdr(sramAdr),
    .memWdata(sramWdata), .memByteEn(sramByteEn),
    .memAck(sramAck), .memRdata(busRdata)
  );

endmodule

//--- design/sramBus.sv
/*
  On-chip word SRAM on the memory bus.
  Byte-enabled writes, registered read data and an acknowledge
  one cycle after each request.
*/
module sramBus import memPkg::*, busPkg::*; (
  input  logic    clk,
  input  logic    arstN,
  input  logic    memReq,
  input  logic    memWrite,
  input  wordAdrT memAdr,
  input  dataT    memWdata,
  input  byteEnT  memByteEn,
  output logic    memAck,
  output dataT    memRdata
);

  dataT mem [MEM_WORDS];
  logic accessNow;

  // power-up contents are zero
  initial begin
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = '0;
    end
  end

  // request still high in its ack cycle is the same access
  assign accessNow = memReq & ~memAck;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN)
      memAck <= 1'b0;
    else
      memAck <= accessNow;
  end

  // read returns the word before any write of the same access
  always_ff @(posedge clk) begin
    if (accessNow) begin
      memRdata <= mem[memAdr];
      if (memWrite) begin
        for (int b = 0; b < $bits(byteEnT); b++) begin
          if (memByteEn[b])
            mem[memAdr][8*b +: 8] <= memWdata[8*b +: 8];
        end
      end
    end
  end

endmodule

//--- filelist.f
design/memPkg.sv
design/busPkg.sv
design/dataMemUnit.sv
design/fetchUnit.sv
design/busArbiter.sv
design/sramBus.sv
design/memSubsystem.sv
testbench/memSubsystemTb.sv

//--- testbench/memSubsystemTb.sv
/*
  Testbench for the memory-stage subsystem.
  Random data accesses, LR/SC, AMO swap and concurrent fetches under
  random stall, checked against a byte-level memory model.
*/
module memSubsystemTb import memPkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_OPS        = 300;
  // worst op with contention and stall stays well below 12 cycles
  localparam int TIMEOUT_CYCLES = 12 * NUM_OPS + 100;
  localparam int RESET_CYCLES   = 16;
  // small window so reservations and fetches hit written words
  localparam int REGION_WORDS   = 64;
  localparam funct3T F3_WORD    = 3'b010;
  localparam atomicT AT_NONE    = 2'b00;
  localparam atomicT AT_LRSC    = 2'b01;
  localparam atomicT AT_SWAP    = 2'b10;

  typedef struct packed {
    memRwT  rw;
    addrT   adr;
    funct3T f3;
    dataT   wdata;
    atomicT atomic;
  } memOpT;

  logic   clk, arstN, stall;
  memRwT  memRw;
  addrT   memAdr;
  funct3T funct3;
  dataT   writeData;
  atomicT atomic;
  dataT   readData;
  logic   dataDone, scFail;
  logic   loadMisalignedFault, storeMisalignedFault;
  logic   loadAccessFault, storeAccessFault;
  logic   fetchReq;
  addrT   fetchAdr;
  dataT   instr;
  logic   fetchDone, fetchMisalignedFault;

  // reference model, byte image of the SRAM plus the reservation
  logic [7:0]  modelMem [MEM_WORDS*4];
  logic        resValid;
  logic [29:0] resWord;

  memOpT      pending[$];
  memOpT      curOp;
  addrT       curFetch;
  integer     seed;
  int         issued, cycles, dPhase, fPhase;
  logic       dSeen, fSeen, readExpected;
  dataT       expRead, expInstr;
  logic [4:0] expFlags;

  memSubsystem dut_i (.*);

  always #2 clk = ~clk;

  task automatic checkValue(input logic [31:0] got, input logic [31:0] exp,
                            input string what);
    if (got !== exp) begin
      $display("ERR %0t ns: %s, got %h, expected %h", $time, what, got, exp);
      $display("SIMULATION FAILED");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  function automatic int pick(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  function automatic memOpT makeOp(input memRwT rw, input addrT adr, input funct3T f3,
                                   input dataT wd, input atomicT at);
    memOpT op;
    op.rw     = rw;
    op.adr    = adr;
    op.f3     = f3;
    op.wdata  = wd;
    op.atomic = at;
    return op;
  endfunction

  function automatic dataT readModelWord(input addrT a);
    dataT w;
    int   idx;
    idx = int'({a[11:2], 2'b00});
    for (int i = 0; i < 4; i++)
      w[8*i +: 8] = modelMem[idx + i];
    return w;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // reference model of one data access
  //////////////////////////////////////////////////////////////////////

  task automatic applyDataModel(input memOpT op);
    logic [1:0] size;
    logic       mis, acc, isLr, isSc, match;
    int         idx, nb;
    dataT       val;
    size  = op.f3[1:0];
    // natural alignment, doubleword counts as an access fault
    mis   = (size == SIZE_HALF && op.adr[0]) || (size == SIZE_WORD && op.adr[1:0] != 2'b00);
    acc   = !mis && (op.adr >= MEM_TOP || size == SIZE_DOUBLE);
    isLr  = (op.rw == RW_READ) && op.atomic[0];
    isSc  = (op.rw == RW_WRITE) && op.atomic[0];
    match = resValid && (resWord == op.adr[31:2]);
    expFlags = {mis & op.rw[1], mis & op.rw[0], acc & op.rw[1], acc & op.rw[0],
                isSc & ~match & ~mis & ~acc};
    readExpected = op.rw[1] && !mis && !acc;
    if (!mis && !acc) begin
      idx = int'(op.adr[11:0]);
      nb  = 1 << size;
      val = '0;
      for (int i = 0; i < nb; i++)
        val[8*i +: 8] = modelMem[idx + i];
      // funct3[2] clear means sign extension
      if (!op.f3[2] && size == SIZE_BYTE)
        val = {{24{val[7]}}, val[7:0]};
      else if (!op.f3[2] && size == SIZE_HALF)
        val = {{16{val[15]}}, val[15:0]};
      expRead = val;
      // plain store, amo write, or sc holding a live reservation
      if ((op.rw[0] && !isSc) || (isSc && match)) begin
        for (int i = 0; i < nb; i++)
          modelMem[idx + i] = op.wdata[8*i +: 8];
      end
      if (isLr) begin
        resValid = 1'b1;
        resWord  = op.adr[31:2];
      end else if (isSc || (op.rw[0] && match)) begin
        resValid = 1'b0;
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // random operation sequences
  //////////////////////////////////////////////////////////////////////

  task automatic queueOps();
    int     kind, size, word, word2;
    addrT   adr, adrB;
    dataT   wd;
    memRwT  rw;
    funct3T f3;
    kind  = pick(16);
    word  = pick(REGION_WORDS);
    word2 = (word + 1 + pick(REGION_WORDS - 1)) % REGION_WORDS;
    wd    = dataT'($random(seed));
    rw    = (pick(2) == 0) ? RW_READ : RW_WRITE;
    adr   = addrT'(4 * word);
    adrB  = addrT'(4 * word2);
    if (kind < 9) begin
      // aligned byte, half or word
      size = pick(3);
      if (size == 0)
        adr = adr + addrT'(pick(4));
      else if (size == 1)
        adr = adr + addrT'(2 * pick(2));
      f3 = funct3T'(size);
      if (rw == RW_READ && size != 2 && pick(2) == 0)
        f3[2] = 1'b1;
      pending.push_back(makeOp(rw, adr, f3, wd, AT_NONE));
    end else if (kind < 11) begin
      // misaligned half or word, then read back the word
      if (pick(2) == 0) begin
        adr = adr + addrT'(1 + 2 * pick(2));
        f3  = 3'b001;
      end else begin
        adr = adr + addrT'(1 + pick(3));
        f3  = F3_WORD;
      end
      pending.push_back(makeOp(rw, adr, f3, wd, AT_NONE));
      pending.push_back(makeOp(RW_READ, addrT'(4 * word), F3_WORD, '0, AT_NONE));
    end else if (kind < 12) begin
      // out of range or doubleword, the read hits the aliased word
      if (pick(2) == 0) begin
        adr = (pick(4) == 0) ? MEM_TOP : MEM_TOP + addrT'(4 * pick(1 << 20));
        f3  = F3_WORD;
      end else begin
        f3  = 3'b011;
      end
      pending.push_back(makeOp(rw, adr, f3, wd, AT_NONE));
      pending.push_back(makeOp(RW_READ, adr & addrT'(32'hffc), F3_WORD, '0, AT_NONE));
    end else if (kind < 14) begin
      pending.push_back(makeOp(RW_READ, adr, F3_WORD, '0, AT_LRSC));
      case (pick(4))
        // byte store into the reserved word
        1: pending.push_back(makeOp(RW_WRITE, adr + addrT'(pick(4)), 3'b000,
                                    dataT'($random(seed)), AT_NONE));
        2: pending.push_back(makeOp(RW_WRITE, adrB, F3_WORD, dataT'($random(seed)), AT_NONE));
        // sc to another word drops the reservation too
        3: pending.push_back(makeOp(RW_WRITE, adrB, F3_WORD, dataT'($random(seed)), AT_LRSC));
        default: ;
      endcase
      pending.push_back(makeOp(RW_WRITE, adr, F3_WORD, wd, AT_LRSC));
      if (pick(2) == 0)
        pending.push_back(makeOp(RW_WRITE, adr, F3_WORD, dataT'($random(seed)), AT_LRSC));
      pending.push_back(makeOp(RW_READ, adr, F3_WORD, '0, AT_NONE));
    end else begin
      // swap returns the old word, the read sees the new one
      pending.push_back(makeOp(RW_AMO, adr, F3_WORD, wd, AT_SWAP));
      pending.push_back(makeOp(RW_READ, adr, F3_WORD, '0, AT_NONE));
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // per-cycle requester handling, called on the falling edge
  //////////////////////////////////////////////////////////////////////

  task automatic dataStep();
    if (dPhase == 1 && dataDone) begin
      if (!dSeen) begin
        // flags are latched at acceptance, model updates at first done
        applyDataModel(curOp);
        checkValue(32'({loadMisalignedFault, storeMisalignedFault, loadAccessFault,
                        storeAccessFault, scFail}), 32'(expFlags), "data fault and scFail flags");
        dSeen = 1'b1;
      end else if (readExpected) begin
        checkValue(readData, expRead, "readData held during stall");
      end
      if (!stall)
        dPhase = 2;
    end else if (dPhase == 2) begin
      if (readExpected)
        checkValue(readData, expRead, "readData after load");
      dPhase = 0;
    end
    if (dPhase == 0) begin
      if (pending.size() == 0 && issued < NUM_OPS)
        queueOps();
      if (pending.size() != 0) begin
        curOp     = pending.pop_front();
        memRw     = curOp.rw;
        memAdr    = curOp.adr;
        funct3    = curOp.f3;
        writeData = curOp.wdata;
        atomic    = curOp.atomic;
        issued++;
        dSeen  = 1'b0;
        dPhase = 1;
      end else begin
        memRw  = '0;
        atomic = '0;
      end
    end
  endtask

  task automatic fetchStep();
    if (fPhase == 1 && fetchDone) begin
      if (!fSeen) begin
        checkValue(32'(fetchMisalignedFault), 32'(curFetch[1:0] != 2'b00),
                   "fetch misaligned fault");
        expInstr = readModelWord(curFetch);
        fSeen    = 1'b1;
      end else if (curFetch[1:0] == 2'b00) begin
        checkValue(instr, expInstr, "instr held during stall");
      end
      if (!stall)
        fPhase = 2;
    end else if (fPhase == 2) begin
      if (curFetch[1:0] == 2'b00)
        checkValue(instr, expInstr, "fetched instruction word");
      fPhase = 0;
    end
    if (fPhase == 0) begin
      if (issued < NUM_OPS && pick(2) == 0) begin
        curFetch = addrT'(4 * pick(REGION_WORDS));
        // about one fetch in eight is off the word boundary
        if (pick(8) == 0)
          curFetch = curFetch + addrT'(1 + pick(3));
        fetchReq = 1'b1;
        fetchAdr = curFetch;
        fSeen    = 1'b0;
        fPhase   = 1;
      end else begin
        fetchReq = 1'b0;
      end
    end
  endtask

  initial begin
    seed      = 58681;
    clk       = 1'b0;
    arstN     = 1'b0;
    stall     = 1'b0;
    memRw     = '0;
    memAdr    = '0;
    funct3    = '0;
    writeData = '0;
    atomic    = '0;
    fetchReq  = 1'b0;
    fetchAdr  = '0;
    for (int i = 0; i < MEM_WORDS * 4; i++)
      modelMem[i] = '0;
    resValid     = 1'b0;
    resWord      = '0;
    issued       = 0;
    cycles       = 0;
    dPhase       = 0;
    fPhase       = 0;
    dSeen        = 1'b0;
    fSeen        = 1'b0;
    readExpected = 1'b0;
    repeat (RESET_CYCLES) @(negedge clk);
    arstN = 1'b1;
    @(negedge clk);
    checkValue(32'({dataDone, fetchDone, scFail, loadMisalignedFault, storeMisalignedFault,
                    loadAccessFault, storeAccessFault, fetchMisalignedFault}), '0,
               "outputs idle after reset");
    while (dPhase != 0 || fPhase != 0 || pending.size() != 0 || issued < NUM_OPS) begin
      @(negedge clk);
      cycles++;
      if (cycles > TIMEOUT_CYCLES) begin
        $display("timeout: requests still open after %0d cycles", TIMEOUT_CYCLES);
        $display("SIMULATION FAILED");
        $fatal(1, "run did not finish in time");
      end
      // new stall first, it governs the coming rising edge
      stall = (pick(4) == 0);
      dataStep();
      fetchStep();
    end
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule
